// File: design/recv_ep_check.sv
`timescale 1ns/1ps
`include "recv_msg_params.svh"

module recv_ep_check (
    input  logic                    clk_i,
    input  logic                    reset_n_i,
    input  logic                    start_i,
    input  recv_msg_pkg::recv_req_t req_i,
    output logic                    done_o,
    output recv_msg_pkg::ep_check_t result_o
);

    // wide enough for any shift by a slot field
    logic [63:0]             slot_bytes;
    logic [63:0]             msg_bytes;
    logic [63:0]             rpl_end;
    recv_msg_pkg::ep_check_t result_d;
    logic                    done_q;
    recv_msg_pkg::ep_check_t result_q;

    always_comb begin
        slot_bytes = 64'd1 << req_i.ep.slot_size_log2;
        msg_bytes  = 64'(req_i.hdr.length) + 64'(`RM_HDR_BYTES);
        rpl_end    = 64'(req_i.ep.rpl_eps) + (64'd1 << req_i.ep.slots_log2);

        result_d.slot_size_log2 = req_i.ep.slot_size_log2;

        // priority: type, then size, then reply endpoint range
        if (req_i.ep.ep_type != recv_msg_pkg::EP_RECEIVE) begin
            result_d.error = recv_msg_pkg::ERR_RECV_GONE;
        end else if (msg_bytes > slot_bytes) begin
            result_d.error = recv_msg_pkg::ERR_OUT_OF_BOUNDS;
        end else if ((req_i.ep.rpl_eps != '1) && (rpl_end > 64'(`RM_EP_COUNT))) begin
            result_d.error = recv_msg_pkg::ERR_INV_RPL_EPS;
        end else begin
            result_d.error = recv_msg_pkg::ERR_NONE;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_n_i) begin
            done_q <= 1'b0;
        end else begin
            done_q <= start_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            result_q <= result_d;
        end
    end

    assign done_o   = done_q;
    assign result_o = result_q;

endmodule

// File: design/recv_msg_pkg.sv
`include "recv_msg_params.svh"

package recv_msg_pkg;

    typedef enum logic [1:0] {
        EP_INVALID = 2'd0,
        EP_SEND    = 2'd1,
        EP_RECEIVE = 2'd2,
        EP_MEMORY  = 2'd3
    } ep_type_e;

    // error codes reported in the acknowledgement
    typedef enum logic [2:0] {
        ERR_NONE          = 3'd0,
        ERR_RECV_GONE     = 3'd1,
        ERR_OUT_OF_BOUNDS = 3'd2,
        ERR_INV_RPL_EPS   = 3'd3,
        ERR_NO_SPACE      = 3'd4,
        ERR_ABORT         = 3'd5
    } rm_error_e;

    // receive endpoint, rpl_eps all ones means no reply endpoints
    typedef struct packed {
        ep_type_e                 ep_type;
        logic [`RM_EP_W-1:0]      rpl_eps;
        logic [`RM_SLOT_W-1:0]    slots_log2;
        logic [`RM_SLOT_W-1:0]    slot_size_log2;
        logic [`RM_SLOT_W-1:0]    wpos;
        logic [`RM_MAX_SLOTS-1:0] occupied;
        logic [`RM_ADDR_W-1:0]    buffer;
    } recv_ep_t;

    typedef struct packed {
        logic                    reply;
        logic [`RM_LEN_W-1:0]    length;
        logic [7:0]              sender_chip;
        logic [15:0]             sender_pe;
        logic [31:0]             label;
    } msg_hdr_t;

    typedef struct packed {
        recv_ep_t                ep;
        msg_hdr_t                hdr;
    } recv_req_t;

    typedef struct packed {
        logic [8*`RM_FLIT_BYTES-1:0] data;
        logic [`RM_FLIT_BYTES-1:0]   bsel;
        logic                        last;
    } noc_flit_t;

    typedef struct packed {
        logic [`RM_ADDR_W-1:0]       addr;
        logic [8*`RM_FLIT_BYTES-1:0] data;
        logic [`RM_FLIT_BYTES-1:0]   be;
    } mem_wr_t;

    typedef struct packed {
        rm_error_e               error;
        logic [`RM_SLOT_W-1:0]   slot_size_log2;
    } ep_check_t;

    typedef struct packed {
        logic                    found;
        logic [`RM_SLOT_W-1:0]   slot;
    } slot_result_t;

    typedef struct packed {
        rm_error_e               error;
        logic [`RM_SLOT_W-1:0]   slot;
        logic [`RM_SLOT_W-1:0]   new_wpos;
        logic [31:0]             label;
        logic [7:0]              sender_chip;
        logic [15:0]             sender_pe;
    } recv_ack_t;

endpackage

// File: design/recv_msg_store.sv
`timescale 1ns/1ps
`include "recv_msg_params.svh"

module recv_msg_store (
    input  logic                       clk_i,
    input  logic                       reset_n_i,
    input  recv_msg_pkg::recv_req_t    req_i,
    input  logic                       check_done_i,
    input  recv_msg_pkg::ep_check_t    check_i,
    input  logic                       search_done_i,
    input  recv_msg_pkg::slot_result_t search_i,
    input  logic                       flit_valid_i,
    input  recv_msg_pkg::noc_flit_t    flit_i,
    output logic                       flit_ready_o,
    output logic                       mem_wr_valid_o,
    output recv_msg_pkg::mem_wr_t      mem_wr_o,
    input  logic                       mem_wr_ready_i,
    output logic                       ack_valid_o,
    output recv_msg_pkg::recv_ack_t    ack_o,
    input  logic                       ack_ready_i,
    output logic                       busy_o
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_WAIT,
        S_DATA,
        S_FLUSH,
        S_ACK
    } state_e;

    state_e                     state_q;
    logic                       have_search_q;
    recv_msg_pkg::rm_error_e    error_q;
    logic                       drain_q;
    logic                       mem_valid_q;

    recv_msg_pkg::recv_req_t    req_q;
    recv_msg_pkg::ep_check_t    check_q;
    recv_msg_pkg::slot_result_t search_q;
    logic [`RM_ADDR_W-1:0]      addr_q;
    recv_msg_pkg::mem_wr_t      mem_q;

    recv_msg_pkg::rm_error_e    merged_error;
    logic [`RM_ADDR_W-1:0]      slot_base;
    logic                       mem_free;
    logic                       flit_accept;
    logic                       flit_writes;

    // ------------------------------
    // result merge
    // ------------------------------
    // check error wins over search result
    always_comb begin
        if (check_q.error != recv_msg_pkg::ERR_NONE) begin
            merged_error = check_q.error;
        end else if (!search_q.found) begin
            merged_error = recv_msg_pkg::ERR_NO_SPACE;
        end else begin
            merged_error = recv_msg_pkg::ERR_NONE;
        end
    end

    assign slot_base = req_q.ep.buffer
                     + (`RM_ADDR_W'(search_q.slot) << check_q.slot_size_log2);

    // ------------------------------
    // flit handshake
    // ------------------------------
    assign mem_free     = !mem_valid_q || mem_wr_ready_i;
    assign flit_ready_o = (state_q == S_DATA) && mem_free;
    assign flit_accept  = flit_valid_i && flit_ready_o;
    // zero bsel aborts and that flit itself is never written
    assign flit_writes  = flit_accept && !drain_q && (flit_i.bsel != '0);

    // check done marks the cycle right after acceptance
    assign busy_o = (state_q != S_IDLE) || check_done_i;

    always_ff @(posedge clk_i) begin
        if (!reset_n_i) begin
            state_q       <= S_IDLE;
            have_search_q <= 1'b0;
            error_q       <= recv_msg_pkg::ERR_NONE;
            drain_q       <= 1'b0;
            mem_valid_q   <= 1'b0;
        end else begin
            if (search_done_i) begin
                have_search_q <= 1'b1;
            end

            if (flit_writes) begin
                mem_valid_q <= 1'b1;
            end else if (mem_wr_ready_i) begin
                mem_valid_q <= 1'b0;
            end

            case (state_q)
                S_IDLE: begin
                    if (check_done_i) begin
                        state_q <= S_WAIT;
                    end
                end
                // check result is already held on entry
                S_WAIT: begin
                    if (have_search_q) begin
                        error_q <= merged_error;
                        drain_q <= (merged_error != recv_msg_pkg::ERR_NONE);
                        state_q <= S_DATA;
                    end
                end
                S_DATA: begin
                    if (flit_accept) begin
                        if (!drain_q && (flit_i.bsel == '0)) begin
                            error_q <= recv_msg_pkg::ERR_ABORT;
                            drain_q <= 1'b1;
                        end
                        // wait for the last write only if one was loaded
                        if (flit_i.last) begin
                            state_q <= flit_writes ? S_FLUSH : S_ACK;
                        end
                    end
                end
                S_FLUSH: begin
                    if (mem_free) begin
                        state_q <= S_ACK;
                    end
                end
                S_ACK: begin
                    if (ack_ready_i) begin
                        state_q       <= S_IDLE;
                        have_search_q <= 1'b0;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        // request is held from the acceptance edge on
        if ((state_q == S_IDLE) && !check_done_i) begin
            req_q <= req_i;
        end
        if (check_done_i) begin
            check_q <= check_i;
        end
        if (search_done_i) begin
            search_q <= search_i;
        end
        if (state_q == S_WAIT) begin
            addr_q <= slot_base;
        end
        if (flit_writes) begin
            mem_q.addr <= addr_q;
            mem_q.data <= flit_i.data;
            mem_q.be   <= flit_i.bsel;
            addr_q     <= addr_q + `RM_ADDR_W'(`RM_FLIT_BYTES);
        end
    end

    assign mem_wr_valid_o = mem_valid_q;
    assign mem_wr_o       = mem_q;

    // ------------------------------
    // acknowledgement
    // ------------------------------
    always_comb begin
        ack_o.error       = error_q;
        ack_o.label       = req_q.hdr.label;
        ack_o.sender_chip = req_q.hdr.sender_chip;
        ack_o.sender_pe   = req_q.hdr.sender_pe;
        if (error_q == recv_msg_pkg::ERR_NONE) begin
            ack_o.slot     = search_q.slot;
            ack_o.new_wpos = search_q.slot + 1'b1;
        end else begin
            ack_o.slot     = '0;
            ack_o.new_wpos = '0;
        end
    end

    assign ack_valid_o = (state_q == S_ACK);

endmodule

// File: design/recv_msg_top.sv
`timescale 1ns/1ps

module recv_msg_top (
    input  logic                    clk_i,
    input  logic                    reset_n_i,

    input  logic                    req_valid_i,
    input  recv_msg_pkg::recv_req_t req_i,
    output logic                    req_ready_o,

    input  logic                    flit_valid_i,
    input  recv_msg_pkg::noc_flit_t flit_i,
    output logic                    flit_ready_o,

    output logic                    mem_wr_valid_o,
    output recv_msg_pkg::mem_wr_t   mem_wr_o,
    input  logic                    mem_wr_ready_i,

    output logic                    ack_valid_o,
    output recv_msg_pkg::recv_ack_t ack_o,
    input  logic                    ack_ready_i
);

    logic                       start;
    logic                       busy;
    logic                       check_done;
    recv_msg_pkg::ep_check_t    check_result;
    logic                       search_done;
    recv_msg_pkg::slot_result_t search_result;

    // one message in flight at a time
    assign req_ready_o = !busy;
    assign start       = req_valid_i && req_ready_o;

    // check and search run side by side on the same request
    recv_ep_check i_recv_ep_check (
        .clk_i     (clk_i),
        .reset_n_i (reset_n_i),
        .start_i   (start),
        .req_i     (req_i),
        .done_o    (check_done),
        .result_o  (check_result)
    );

    recv_slot_search i_recv_slot_search (
        .clk_i     (clk_i),
        .reset_n_i (reset_n_i),
        .start_i   (start),
        .ep_i      (req_i.ep),
        .done_o    (search_done),
        .result_o  (search_result)
    );

    recv_msg_store i_recv_msg_store (
        .clk_i          (clk_i),
        .reset_n_i      (reset_n_i),
        .req_i          (req_i),
        .check_done_i   (check_done),
        .check_i        (check_result),
        .search_done_i  (search_done),
        .search_i       (search_result),
        .flit_valid_i   (flit_valid_i),
        .flit_i         (flit_i),
        .flit_ready_o   (flit_ready_o),
        .mem_wr_valid_o (mem_wr_valid_o),
        .mem_wr_o       (mem_wr_o),
        .mem_wr_ready_i (mem_wr_ready_i),
        .ack_valid_o    (ack_valid_o),
        .ack_o          (ack_o),
        .ack_ready_i    (ack_ready_i),
        .busy_o         (busy)
    );

endmodule

// File: design/recv_slot_search.sv
`timescale 1ns/1ps
`include "recv_msg_params.svh"

module recv_slot_search (
    input  logic                       clk_i,
    input  logic                       reset_n_i,
    input  logic                       start_i,
    input  recv_msg_pkg::recv_ep_t     ep_i,
    output logic                       done_o,
    output recv_msg_pkg::slot_result_t result_o
);

    logic [`RM_SLOT_W-1:0]    start_cnt;
    logic [`RM_SLOT_W-1:0]    start_pos;
    logic [`RM_SLOT_W-1:0]    cur_pos;
    logic [`RM_SLOT_W-1:0]    cur_cnt;
    logic [`RM_SLOT_W-1:0]    cur_left;
    logic [`RM_MAX_SLOTS-1:0] cur_occ;
    logic [`RM_SLOT_W-1:0]    pos_inc;
    logic                     examining;
    logic                     hit;
    logic                     is_last;

    logic                       active_q;
    logic                       done_q;
    logic [`RM_SLOT_W-1:0]      pos_q;
    logic [`RM_SLOT_W-1:0]      cnt_q;
    logic [`RM_SLOT_W-1:0]      left_q;
    logic [`RM_MAX_SLOTS-1:0]   occ_q;
    recv_msg_pkg::slot_result_t result_q;

    // slot count capped at the mask width
    always_comb begin
        if (ep_i.slots_log2 >= `RM_SLOT_W'($clog2(`RM_MAX_SLOTS))) begin
            start_cnt = `RM_SLOT_W'(`RM_MAX_SLOTS);
        end else begin
            start_cnt = `RM_SLOT_W'(1) << ep_i.slots_log2;
        end
        start_pos = (ep_i.wpos < start_cnt) ? ep_i.wpos : '0;
    end

    // first slot is looked at in the start cycle itself
    assign examining = start_i || active_q;
    assign cur_pos   = start_i ? start_pos : pos_q;
    assign cur_cnt   = start_i ? start_cnt : cnt_q;
    assign cur_left  = start_i ? start_cnt - 1'b1 : left_q;
    assign cur_occ   = start_i ? ep_i.occupied : occ_q;

    // position never reaches the count, so the low bits index the mask
    assign hit     = !cur_occ[cur_pos[$clog2(`RM_MAX_SLOTS)-1:0]];
    assign is_last = hit || (cur_left == '0);
    // wrap at the slot count
    assign pos_inc = (cur_pos + 1'b1 == cur_cnt) ? '0 : cur_pos + 1'b1;

    always_ff @(posedge clk_i) begin
        if (!reset_n_i) begin
            active_q <= 1'b0;
            done_q   <= 1'b0;
        end else begin
            active_q <= examining && !is_last;
            done_q   <= examining && is_last;
        end
    end

    always_ff @(posedge clk_i) begin
        if (examining) begin
            pos_q  <= pos_inc;
            cnt_q  <= cur_cnt;
            left_q <= cur_left - 1'b1;
            occ_q  <= cur_occ;
            if (is_last) begin
                result_q.found <= hit;
                result_q.slot  <= cur_pos;
            end
        end
    end

    assign done_o   = done_q;
    assign result_o = result_q;

endmodule

// File: dv/recv_msg_tb.sv
`timescale 1ns/1ps
`include "recv_msg_params.svh"

module recv_msg_tb;

    localparam int NUM_CASES   = 16;
    localparam int MAX_FLITS   = 16;
    localparam int CYCLE_LIMIT = NUM_CASES * (`RM_MAX_SLOTS + MAX_FLITS + 40);
    localparam logic [7:0] NO_ZERO = 8'hff;

    // short names for the case table
    localparam recv_msg_pkg::ep_type_e  RX   = recv_msg_pkg::EP_RECEIVE;
    localparam recv_msg_pkg::ep_type_e  SX   = recv_msg_pkg::EP_SEND;
    localparam recv_msg_pkg::ep_type_e  MX   = recv_msg_pkg::EP_MEMORY;
    localparam recv_msg_pkg::rm_error_e OK   = recv_msg_pkg::ERR_NONE;
    localparam recv_msg_pkg::rm_error_e GONE = recv_msg_pkg::ERR_RECV_GONE;
    localparam recv_msg_pkg::rm_error_e OOB  = recv_msg_pkg::ERR_OUT_OF_BOUNDS;
    localparam recv_msg_pkg::rm_error_e RPL  = recv_msg_pkg::ERR_INV_RPL_EPS;
    localparam recv_msg_pkg::rm_error_e NOSP = recv_msg_pkg::ERR_NO_SPACE;
    localparam recv_msg_pkg::rm_error_e ABRT = recv_msg_pkg::ERR_ABORT;

    typedef struct packed {
        recv_msg_pkg::ep_type_e  ep_type;
        logic [`RM_EP_W-1:0]     rpl_eps;
        logic [`RM_SLOT_W-1:0]   slots_log2;
        logic [`RM_SLOT_W-1:0]   slot_size_log2;
        logic [`RM_SLOT_W-1:0]   wpos;
        logic [31:0]             occupied;
        logic [31:0]             buffer;
        logic [`RM_LEN_W-1:0]    length;
        logic                    reply;
        logic [7:0]              zero_idx;
        logic                    stall;
        recv_msg_pkg::rm_error_e exp_error;
    } case_t;

    logic                    clk;
    logic                    reset_n;
    logic                    req_valid;
    recv_msg_pkg::recv_req_t req_in;
    logic                    req_ready;
    logic                    flit_valid;
    recv_msg_pkg::noc_flit_t flit_in;
    logic                    flit_ready;
    logic                    mem_wr_valid;
    recv_msg_pkg::mem_wr_t   mem_wr;
    logic                    mem_ready;
    logic                    ack_valid;
    recv_msg_pkg::recv_ack_t ack;
    logic                    ack_ready;

    case_t        cases [NUM_CASES];
    logic [127:0] flit_data [MAX_FLITS];
    logic [15:0]  flit_bsel [MAX_FLITS];
    logic [15:0]  lfsr_state;
    int           errors;
    int           checks;
    int           cur_case;
    int           cycle_cnt = 0;

    recv_msg_top i_recv_msg_top (
        .clk_i          (clk),
        .reset_n_i      (reset_n),
        .req_valid_i    (req_valid),
        .req_i          (req_in),
        .req_ready_o    (req_ready),
        .flit_valid_i   (flit_valid),
        .flit_i         (flit_in),
        .flit_ready_o   (flit_ready),
        .mem_wr_valid_o (mem_wr_valid),
        .mem_wr_o       (mem_wr),
        .mem_wr_ready_i (mem_ready),
        .ack_valid_o    (ack_valid),
        .ack_o          (ack),
        .ack_ready_i    (ack_ready)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > CYCLE_LIMIT) begin
            $display("timeout after %0d cycles in case %0d, no acknowledgement", cycle_cnt,
                     cur_case);
            $display("TB FAILED");
            $finish;
        end
    end

    // ------------------------------
    // helpers
    // ------------------------------
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hb400;
        end
        return s >> 1;
    endfunction

    // one lfsr step per bit taken
    task automatic random_bits(input int n, output logic [127:0] v);
        v = '0;
        for (int b = 0; b < n; b++) begin
            v[b]       = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // {found, slot}: first clear bit from wpos upward, wrapping at the slot count
    function automatic logic [6:0] find_slot(input logic [5:0] slots_log2,
                                             input logic [5:0] wpos, input logic [31:0] occ);
        int         count;
        int         first;
        int         p;
        logic [6:0] res;
        if (int'(slots_log2) >= $clog2(`RM_MAX_SLOTS)) begin
            count = `RM_MAX_SLOTS;
        end else begin
            count = 1 << slots_log2;
        end
        first = (int'(wpos) < count) ? int'(wpos) : 0;
        res   = '0;
        for (int i = 0; i < count; i++) begin
            p = (first + i) % count;
            if (!res[6] && !occ[p]) begin
                res = {1'b1, 6'(p)};
            end
        end
        return res;
    endfunction

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s case %0d got=%h exp=%h", name, cur_case, got, exp);
        end
    endtask

    task automatic load_cases();
        // type, rpl, slots_log2, size_log2, wpos, occupied, buffer, len, reply,
        // zero bsel flit, stalls, expected error
        cases[0]  = '{RX, 8'hff, 6'd3, 6'd6, 6'd2,  32'h0, 32'h1000, 16'd40, 1'b0, NO_ZERO, 1'b0, OK};
        cases[1]  = '{RX, 8'hff, 6'd3, 6'd7, 6'd5, 32'h60, 32'h2000, 16'd100, 1'b1, NO_ZERO, 1'b0, OK};
        cases[2]  = '{RX, 8'd10, 6'd2, 6'd6, 6'd2,  32'he, 32'h3000, 16'd0, 1'b0, NO_ZERO, 1'b0, OK};
        cases[3]  = '{RX, 8'hff, 6'd2, 6'd6, 6'd9,  32'h3, 32'h3000, 16'd30, 1'b0, NO_ZERO, 1'b0, OK};
        cases[4]  = '{RX, 8'hff, 6'd4, 6'd6, 6'd3, 32'hffff, 32'h4000, 16'd20, 1'b0, NO_ZERO, 1'b0,
                      NOSP};
        cases[5]  = '{RX, 8'hff, 6'd6, 6'd5, 6'd31, 32'hffff_fffe, 32'h5000, 16'd10, 1'b0, NO_ZERO,
                      1'b0, OK};
        cases[6]  = '{SX, 8'hff, 6'd3, 6'd6, 6'd0,  32'h0, 32'h6000, 16'd200, 1'b0, NO_ZERO, 1'b0,
                      GONE};
        cases[7]  = '{RX, 8'd126, 6'd3, 6'd6, 6'd0, 32'h0, 32'h7000, 16'd60, 1'b0, NO_ZERO, 1'b0, OOB};
        cases[8]  = '{RX, 8'd125, 6'd2, 6'd6, 6'd0, 32'h0, 32'h8000, 16'd8, 1'b1, NO_ZERO, 1'b0, RPL};
        cases[9]  = '{RX, 8'd124, 6'd2, 6'd5, 6'd1, 32'h0, 32'h9000, 16'd16, 1'b0, NO_ZERO, 1'b0, OK};
        cases[10] = '{RX, 8'hff, 6'd3, 6'd7, 6'd0,  32'h1, 32'ha000, 16'd64, 1'b0, 8'd2, 1'b0, ABRT};
        cases[11] = '{RX, 8'hff, 6'd3, 6'd6, 6'd4,  32'h0, 32'hb000, 16'd20, 1'b0, 8'd0, 1'b0, ABRT};
        cases[12] = '{RX, 8'hff, 6'd5, 6'd8, 6'd3, 32'h0f0f_00ff, 32'hc000, 16'd150, 1'b0, NO_ZERO,
                      1'b1, OK};
        cases[13] = '{RX, 8'hff, 6'd4, 6'd7, 6'd6, 32'hc0, 32'hd000, 16'd90, 1'b0, 8'd3, 1'b1, ABRT};
        cases[14] = '{RX, 8'd127, 6'd1, 6'd6, 6'd0, 32'h0, 32'he000, 16'd40, 1'b0, NO_ZERO, 1'b1, RPL};
        cases[15] = '{MX, 8'hff, 6'd2, 6'd4, 6'd0,  32'hf, 32'hf000, 16'd4, 1'b0, 8'd1, 1'b1, GONE};
    endtask

    // ------------------------------
    // one message per case
    // ------------------------------
    task automatic run_case(input int idx);
        case_t                   tc;
        recv_msg_pkg::recv_req_t req;
        logic [127:0]            bits;
        logic [6:0]              search;
        logic [31:0]             base;
        logic [5:0]              exp_slot;
        logic [5:0]              exp_wpos;
        int                      total;
        int                      left;
        int                      nflits;
        int                      nwrites;
        int                      flit_idx;
        int                      wr_idx;
        logic                    req_done;
        logic                    ack_done;
        tc       = cases[idx];
        cur_case = idx;

        req.ep.ep_type        = tc.ep_type;
        req.ep.rpl_eps        = tc.rpl_eps;
        req.ep.slots_log2     = tc.slots_log2;
        req.ep.slot_size_log2 = tc.slot_size_log2;
        req.ep.wpos           = tc.wpos;
        req.ep.occupied       = tc.occupied;
        req.ep.buffer         = tc.buffer;
        req.hdr.reply         = tc.reply;
        req.hdr.length        = tc.length;
        random_bits(32, bits);
        req.hdr.label = bits[31:0];
        random_bits(8, bits);
        req.hdr.sender_chip = bits[7:0];
        random_bits(16, bits);
        req.hdr.sender_pe = bits[15:0];

        // header flit first, then payload, last flit partly filled
        total  = int'(tc.length) + `RM_HDR_BYTES;
        nflits = (total + `RM_FLIT_BYTES - 1) / `RM_FLIT_BYTES;
        for (int k = 0; k < nflits; k++) begin
            random_bits(128, bits);
            flit_data[k] = bits;
            left         = total - k * `RM_FLIT_BYTES;
            if (left >= `RM_FLIT_BYTES) begin
                flit_bsel[k] = '1;
            end else begin
                flit_bsel[k] = 16'((32'd1 << left) - 32'd1);
            end
            if (k == int'(tc.zero_idx)) begin
                flit_bsel[k] = '0;
            end
        end

        search = find_slot(tc.slots_log2, tc.wpos, tc.occupied);
        base   = tc.buffer + (32'(search[5:0]) << tc.slot_size_log2);
        if (tc.exp_error == OK) begin
            nwrites  = nflits;
            exp_slot = search[5:0];
            exp_wpos = search[5:0] + 6'd1;
        end else begin
            nwrites  = (tc.exp_error == ABRT) ? int'(tc.zero_idx) : 0;
            exp_slot = '0;
            exp_wpos = '0;
        end

        req_done = 1'b0;
        ack_done = 1'b0;
        flit_idx = 0;
        wr_idx   = 0;
        while (!ack_done) begin
            @(negedge clk);
            req_valid  = !req_done;
            req_in     = req;
            flit_valid = req_done && (flit_idx < nflits);
            if (flit_idx < nflits) begin
                flit_in.data = flit_data[flit_idx];
                flit_in.bsel = flit_bsel[flit_idx];
                flit_in.last = (flit_idx == nflits - 1);
            end
            if (tc.stall) begin
                random_bits(1, bits);
                mem_ready = bits[0];
                random_bits(1, bits);
                ack_ready = bits[0];
            end else begin
                mem_ready = 1'b1;
                ack_ready = 1'b1;
            end

            // settled well before the next rising edge
            #1;
            if (req_done && req_ready) begin
                errors++;
                $display("case %0d: request port ready while a message is in flight", idx);
            end
            if (req_valid && req_ready) begin
                req_done = 1'b1;
            end
            if (flit_valid && flit_ready) begin
                flit_idx++;
            end
            if (mem_wr_valid && mem_ready) begin
                if (wr_idx >= nwrites) begin
                    errors++;
                    $display("case %0d: unexpected memory write to address %h", idx, mem_wr.addr);
                end else begin
                    check_value("mem_wr.addr", 128'(mem_wr.addr),
                                128'(base + 32'(wr_idx * `RM_FLIT_BYTES)));
                    check_value("mem_wr.data", mem_wr.data, flit_data[wr_idx]);
                    check_value("mem_wr.be", 128'(mem_wr.be), 128'(flit_bsel[wr_idx]));
                end
                wr_idx++;
            end
            if (ack_valid && ack_ready) begin
                check_value("ack.error", 128'(ack.error), 128'(tc.exp_error));
                check_value("ack.slot", 128'(ack.slot), 128'(exp_slot));
                check_value("ack.new_wpos", 128'(ack.new_wpos), 128'(exp_wpos));
                check_value("ack.label", 128'(ack.label), 128'(req.hdr.label));
                check_value("ack.sender_chip", 128'(ack.sender_chip), 128'(req.hdr.sender_chip));
                check_value("ack.sender_pe", 128'(ack.sender_pe), 128'(req.hdr.sender_pe));
                ack_done = 1'b1;
            end
        end
        check_value("write_count", 128'(wr_idx), 128'(nwrites));
        check_value("flit_count", 128'(flit_idx), 128'(nflits));
    endtask

    initial begin
        clk        = 1'b0;
        reset_n    = 1'b0;
        req_valid  = 1'b0;
        req_in     = '0;
        flit_valid = 1'b0;
        flit_in    = '0;
        mem_ready  = 1'b0;
        ack_ready  = 1'b0;
        errors     = 0;
        checks     = 0;
        cur_case   = -1;
        lfsr_state = 16'd85;
        load_cases();

        repeat (8) @(negedge clk);
        reset_n = 1'b1;
        #1;
        // idle state straight out of reset
        check_value("req_ready", 128'(req_ready), 128'(1'b1));
        check_value("flit_ready", 128'(flit_ready), 128'(1'b0));
        check_value("mem_wr_valid", 128'(mem_wr_valid), 128'(1'b0));
        check_value("ack_valid", 128'(ack_valid), 128'(1'b0));

        for (int i = 0; i < NUM_CASES; i++) begin
            run_case(i);
        end

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: include/recv_msg_params.svh
`ifndef RECV_MSG_PARAMS_SVH
`define RECV_MSG_PARAMS_SVH

// ------------------------------
// flit and memory geometry
// ------------------------------
// one flit fills one memory row
`define RM_FLIT_BYTES 16
`define RM_ADDR_W     32
`define RM_LEN_W      16

// ------------------------------
// endpoints and slots
// ------------------------------
`define RM_EP_W       8
`define RM_EP_COUNT   128
`define RM_SLOT_W     6
// occupied mask has one bit per slot
`define RM_MAX_SLOTS  32

// header flit stored ahead of payload
`define RM_HDR_BYTES  16

`endif

// File: recv_msg.f
+incdir+include
design/recv_msg_pkg.sv
design/recv_ep_check.sv
design/recv_slot_search.sv
design/recv_msg_store.sv
design/recv_msg_top.sv
dv/recv_msg_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0)")" 2>/dev/null || cd "$(dirname "$0")" || exit 1
verilator --binary -j 0 --top-module recv_msg_tb -o recv_msg_sim -f recv_msg.f \
    || { echo "build failed"; exit 1; }
out="$(./obj_dir/recv_msg_sim)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "TB PASSED" && exit 0 || exit 1
